/* hw/dbg_mon_pkg.sv */
// Shared constants assume RV32 encodings; only the SYSTEM-format fields needed here are named
`default_nettype none

package dbg_mon_pkg;

  // --------------------
  // Widths
  // --------------------

  // Word, pc and address width
  localparam int XLEN = 32;

  // --------------------
  // Instruction encodings
  // --------------------

  localparam logic [6:0]      OPC_SYSTEM    = 7'b1110011;
  localparam logic [11:0]     F12_EBREAK    = 12'h001;
  localparam logic [11:0]     F12_WFI       = 12'h105;
  localparam logic [11:0]     F12_DRET      = 12'h7B2;
  // Compressed ebreak sits in the low half, upper half zero
  localparam logic [XLEN-1:0] C_EBREAK_WORD = 32'h0000_9002;

  // --------------------
  // Debug cause codes
  // --------------------

  localparam logic [2:0] CAUSE_NONE    = 3'd0;
  localparam logic [2:0] CAUSE_EBREAK  = 3'd1;
  localparam logic [2:0] CAUSE_TRIGGER = 3'd2;
  localparam logic [2:0] CAUSE_HALTREQ = 3'd3;
  localparam logic [2:0] CAUSE_STEP    = 3'd4;

  // --------------------
  // Controller states
  // --------------------

  // Codes above ST_DEBUG_TAKEN are treated as idle
  localparam logic [2:0] ST_RESET       = 3'd0;
  localparam logic [2:0] ST_BOOT_SET    = 3'd1;
  localparam logic [2:0] ST_FUNCTIONAL  = 3'd2;
  localparam logic [2:0] ST_DEBUG_TAKEN = 3'd3;

  // dcsr fields
  localparam int DCSR_STEP_BIT    = 2;
  localparam int DCSR_EBREAKM_BIT = 15;

  // --------------------
  // Retired instruction word
  // --------------------

  // Raw view for exact matches, system view for I-type SYSTEM decode
  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      logic [11:0] funct12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } sys;
  } instr_word_u;

endpackage : dbg_mon_pkg

`default_nettype wire

/* hw/wb_retire_if.sv */
// Write-back retirement bus; the decode flags are only meaningful while wb_valid is high
`timescale 1ns/10ps
`default_nettype none

interface wb_retire_if
  import dbg_mon_pkg::*;
();

  // Retirement stream
  logic        wb_valid;
  logic [XLEN-1:0] wb_pc;
  instr_word_u wb_instr;
  logic        debug_mode;

  // Decoded class of the retiring instruction
  logic is_ebreak;
  logic is_cebreak;
  logic is_wfi;
  logic is_dret;

  modport decoder (
    input  wb_valid, wb_pc, wb_instr,
    output is_ebreak, is_cebreak, is_wfi, is_dret
  );

  modport tracker (
    input wb_valid, wb_pc, wb_instr, debug_mode,
    input is_ebreak, is_cebreak, is_wfi, is_dret
  );

  modport capture (
    input wb_valid, wb_pc, wb_instr, debug_mode,
    input is_ebreak, is_cebreak, is_wfi, is_dret
  );

endinterface : wb_retire_if

`default_nettype wire

/* hw/retire_decoder.sv */
// Flags are combinational on the retiring word; ebreak_pc_o lags the ebreak by one clock
`timescale 1ns/10ps
`default_nettype none

module retire_decoder
  import dbg_mon_pkg::*;
(
  input  wire              cov_assert_if,
  input  wire              rst_n_i,
  wb_retire_if.decoder     bus,
  output logic [XLEN-1:0]  ebreak_pc_o
);

  // --------------------
  // SYSTEM decode
  // --------------------

  logic            sys_base;
  logic            ebreak_hit;
  logic            cebreak_hit;
  logic            wfi_hit;
  logic            dret_hit;
  logic [XLEN-1:0] ebreak_pc_q;

  // ebreak, wfi and dret share opcode with all register fields zero
  assign sys_base = (bus.wb_instr.sys.opcode == OPC_SYSTEM) &&
                    (bus.wb_instr.sys.funct3 == 3'b000) &&
                    (bus.wb_instr.sys.rs1 == 5'd0) &&
                    (bus.wb_instr.sys.rd == 5'd0);

  assign ebreak_hit = sys_base && (bus.wb_instr.sys.funct12 == F12_EBREAK);
  assign wfi_hit    = sys_base && (bus.wb_instr.sys.funct12 == F12_WFI);
  assign dret_hit   = sys_base && (bus.wb_instr.sys.funct12 == F12_DRET);

  // Compressed form needs the full word, upper half must be zero
  assign cebreak_hit = (bus.wb_instr.raw == C_EBREAK_WORD);

  // Only a retiring instruction counts
  assign bus.is_ebreak  = bus.wb_valid && ebreak_hit;
  assign bus.is_cebreak = bus.wb_valid && cebreak_hit;
  assign bus.is_wfi     = bus.wb_valid && wfi_hit;
  assign bus.is_dret    = bus.wb_valid && dret_hit;

  // --------------------
  // Last ebreak pc
  // --------------------

  // Either ebreak form updates the same register
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      ebreak_pc_q <= '0;
    end else if (bus.is_ebreak || bus.is_cebreak) begin
      ebreak_pc_q <= bus.wb_pc;
    end
  end

  assign ebreak_pc_o = ebreak_pc_q;

endmodule : retire_decoder

`default_nettype wire

/* hw/debug_cause_tracker.sv */
// Cause only moves in FUNCTIONAL outside debug mode; first_debug_ins_o needs id_valid_i seen first
`timescale 1ns/10ps
`default_nettype none

module debug_cause_tracker
  import dbg_mon_pkg::*;
#(
  parameter int IRQ_W = 32
) (
  input  wire              cov_assert_if,
  input  wire              rst_n_i,
  wb_retire_if.tracker     bus,
  input  wire              id_valid_i,
  input  wire              debug_req_i,
  input  wire              trigger_match_i,
  input  wire [XLEN-1:0]   dcsr_i,
  input  wire [2:0]        ctrl_state_i,
  input  wire [IRQ_W-1:0]  irq_i,
  input  wire [IRQ_W-1:0]  mie_i,
  output logic [2:0]       cause_o,
  output logic             in_wfi_o,
  output logic             first_debug_ins_o
);

  logic       step_en;
  logic       ebreakm_en;
  logic       any_ebreak;
  logic       cause_update;
  logic [2:0] cause_next;
  logic [2:0] cause_q;
  logic       irq_pending;
  logic       wfi_sleep;
  logic       wfi_wake;
  logic       in_wfi_q;
  logic       started_decoding_q;
  logic       first_seen_q;

  assign step_en    = dcsr_i[DCSR_STEP_BIT];
  assign ebreakm_en = dcsr_i[DCSR_EBREAKM_BIT];
  assign any_ebreak = bus.is_ebreak || bus.is_cebreak;

  // --------------------
  // Expected debug cause
  // --------------------

  assign cause_update = (ctrl_state_i == ST_FUNCTIONAL) && !bus.debug_mode;

  // Fixed priority, trigger highest and step lowest
  always_comb begin
    if (trigger_match_i) begin
      cause_next = CAUSE_TRIGGER;
    end else if (ebreakm_en && any_ebreak) begin
      cause_next = CAUSE_EBREAK;
    end else if (debug_req_i) begin
      cause_next = CAUSE_HALTREQ;
    end else if (step_en) begin
      cause_next = CAUSE_STEP;
    end else begin
      cause_next = CAUSE_NONE;
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      cause_q <= CAUSE_NONE;
    end else if (cause_update) begin
      cause_q <= cause_next;
    end
  end

  // --------------------
  // Wfi sleep
  // --------------------

  assign irq_pending = |(irq_i & mie_i);
  assign wfi_sleep   = bus.is_wfi && !debug_req_i && !bus.debug_mode && !step_en;
  assign wfi_wake    = irq_pending || debug_req_i;

  // Wake takes precedence over a wfi in the same cycle
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      in_wfi_q <= 1'b0;
    end else if (wfi_wake) begin
      in_wfi_q <= 1'b0;
    end else if (wfi_sleep) begin
      in_wfi_q <= 1'b1;
    end
  end

  // --------------------
  // First debug instruction
  // --------------------

  // Flags live for one debug session only
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i || !bus.debug_mode) begin
      started_decoding_q <= 1'b0;
      first_seen_q       <= 1'b0;
    end else begin
      if (id_valid_i) started_decoding_q <= 1'b1;
      if (bus.wb_valid) first_seen_q <= 1'b1;
    end
  end

  assign first_debug_ins_o = bus.debug_mode && bus.wb_valid &&
                             started_decoding_q && !first_seen_q;

  assign cause_o  = cause_q;
  assign in_wfi_o = in_wfi_q;

endmodule : debug_cause_tracker

`default_nettype wire

/* hw/entry_addr_capture.sv */
// Captured addresses are word aligned and read 0 until the first capture after reset
`timescale 1ns/10ps
`default_nettype none

module entry_addr_capture
  import dbg_mon_pkg::*;
(
  input  wire              cov_assert_if,
  input  wire              rst_n_i,
  wb_retire_if.capture     bus,
  input  wire [2:0]        ctrl_state_i,
  input  wire              illegal_insn_i,
  input  wire              ecall_insn_i,
  input  wire              pc_set_i,
  input  wire [XLEN-1:0]   dm_halt_addr_i,
  input  wire [XLEN-1:0]   dm_exception_addr_i,
  output logic [XLEN-1:0]  halt_addr_o,
  output logic [XLEN-1:0]  exc_addr_o
);

  logic [XLEN-1:0] halt_addr_q;
  logic            halt_flag_q;
  logic            halt_take;
  logic            halt_rearm;
  logic [XLEN-1:0] exc_addr_q;
  logic            exc_take;

  // --------------------
  // Halt address
  // --------------------

  // Captured once per entry until debug exit or a debug-mode ebreak rearms it
  assign halt_take  = !halt_flag_q && (ctrl_state_i == ST_DEBUG_TAKEN);
  assign halt_rearm = !bus.debug_mode ||
                      (bus.debug_mode && (bus.is_ebreak || bus.is_cebreak));

  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      halt_addr_q <= '0;
      halt_flag_q <= 1'b0;
    end else begin
      if (halt_take) begin
        halt_addr_q <= {dm_halt_addr_i[XLEN-1:2], 2'b00};
        halt_flag_q <= 1'b1;
      end
      // Rearm overrides the set
      if (halt_rearm) halt_flag_q <= 1'b0;
    end
  end

  // --------------------
  // Exception address
  // --------------------

  assign exc_take = (illegal_insn_i || ecall_insn_i) && pc_set_i &&
                    bus.debug_mode && bus.wb_valid;

  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      exc_addr_q <= '0;
    end else if (exc_take) begin
      exc_addr_q <= {dm_exception_addr_i[XLEN-1:2], 2'b00};
    end
  end

  assign halt_addr_o = halt_addr_q;
  assign exc_addr_o  = exc_addr_q;

endmodule : entry_addr_capture

`default_nettype wire

/* hw/debug_monitor_top.sv */
// Samples every clock with no back-pressure; irq_i and mie_i must both be IRQ_W wide
`timescale 1ns/10ps
`default_nettype none

module debug_monitor_top
  import dbg_mon_pkg::*;
#(
  parameter int IRQ_W = 32
) (
  input  wire              cov_assert_if,
  input  wire              rst_n_i,
  // Write-back stage
  input  wire              wb_valid_i,
  input  wire [XLEN-1:0]   wb_pc_i,
  input  wire [XLEN-1:0]   wb_instr_i,
  // Core debug controls
  input  wire              id_valid_i,
  input  wire              debug_mode_i,
  input  wire              debug_req_i,
  input  wire              trigger_match_i,
  input  wire [XLEN-1:0]   dcsr_i,
  input  wire [2:0]        ctrl_state_i,
  input  wire [IRQ_W-1:0]  irq_i,
  input  wire [IRQ_W-1:0]  mie_i,
  input  wire              illegal_insn_i,
  input  wire              ecall_insn_i,
  input  wire              pc_set_i,
  input  wire [XLEN-1:0]   dm_halt_addr_i,
  input  wire [XLEN-1:0]   dm_exception_addr_i,
  // Monitor results
  output logic             is_ebreak_o,
  output logic             is_cebreak_o,
  output logic             is_wfi_o,
  output logic             is_dret_o,
  output logic [XLEN-1:0]  ebreak_pc_o,
  output logic [2:0]       cause_o,
  output logic             in_wfi_o,
  output logic             first_debug_ins_o,
  output logic [XLEN-1:0]  halt_addr_o,
  output logic [XLEN-1:0]  exc_addr_o
);

  wb_retire_if retire_bus ();

  // --------------------
  // Ports onto the bus
  // --------------------

  assign retire_bus.wb_valid     = wb_valid_i;
  assign retire_bus.wb_pc        = wb_pc_i;
  assign retire_bus.wb_instr.raw = wb_instr_i;
  assign retire_bus.debug_mode   = debug_mode_i;

  assign is_ebreak_o  = retire_bus.is_ebreak;
  assign is_cebreak_o = retire_bus.is_cebreak;
  assign is_wfi_o     = retire_bus.is_wfi;
  assign is_dret_o    = retire_bus.is_dret;

  // --------------------
  // Monitor blocks
  // --------------------

  retire_decoder retire_decoder_inst (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .bus           (retire_bus.decoder),
    .ebreak_pc_o   (ebreak_pc_o)
  );

  debug_cause_tracker #(
    .IRQ_W (IRQ_W)
  ) debug_cause_tracker_inst (
    .cov_assert_if     (cov_assert_if),
    .rst_n_i           (rst_n_i),
    .bus               (retire_bus.tracker),
    .id_valid_i        (id_valid_i),
    .debug_req_i       (debug_req_i),
    .trigger_match_i   (trigger_match_i),
    .dcsr_i            (dcsr_i),
    .ctrl_state_i      (ctrl_state_i),
    .irq_i             (irq_i),
    .mie_i             (mie_i),
    .cause_o           (cause_o),
    .in_wfi_o          (in_wfi_o),
    .first_debug_ins_o (first_debug_ins_o)
  );

  entry_addr_capture entry_addr_capture_inst (
    .cov_assert_if       (cov_assert_if),
    .rst_n_i             (rst_n_i),
    .bus                 (retire_bus.capture),
    .ctrl_state_i        (ctrl_state_i),
    .illegal_insn_i      (illegal_insn_i),
    .ecall_insn_i        (ecall_insn_i),
    .pc_set_i            (pc_set_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .halt_addr_o         (halt_addr_o),
    .exc_addr_o          (exc_addr_o)
  );

endmodule : debug_monitor_top

`default_nettype wire

/* verification/tb_clk_gen.sv */
// Free-running testbench clock that starts low; the period is set in ns by PERIOD_NS
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half period high, half period low
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule : tb_clk_gen

`default_nettype wire

/* verification/tb_tests.svh */
// Directed tests, included inside tb_debug_monitor; each one leaves the inputs idle when done
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

task automatic test_reset_values();
  test_name = "reset";
  @(negedge cov_assert_if);
  check_cause("cause_o", CAUSE_NONE, cause_o);
  check_flag("in_wfi_o", 1'b0, in_wfi_o);
  check_flag("first_debug_ins_o", 1'b0, first_debug_ins_o);
  check_word("ebreak_pc_o", '0, ebreak_pc_o);
  check_word("halt_addr_o", '0, halt_addr_o);
  check_word("exc_addr_o", '0, exc_addr_o);
endtask

// Known words and near misses first, then random words
task automatic test_decode();
  logic [XLEN-1:0] words [6];
  logic [XLEN-1:0] word;
  logic [3:0]      exp;
  test_name = "decode";
  words[0] = EBREAK_WORD;
  words[1] = C_EBREAK_WORD;
  words[2] = WFI_WORD;
  words[3] = DRET_WORD;
  words[4] = EBREAK_WORD | 32'h0000_8000;
  words[5] = C_EBREAK_WORD | 32'h0001_0000;
  for (int i = 0; i < 22; i++) begin
    if (i < 6) word = words[i];
    else word = $random(seed);
    for (int v = 0; v < 2; v++) begin
      @(posedge cov_assert_if);
      wb_valid_i <= v[0];
      wb_instr_i <= word;
      @(negedge cov_assert_if);
      exp = decode_model(v[0], word);
      check_flag("is_ebreak_o", exp[3], is_ebreak_o);
      check_flag("is_cebreak_o", exp[2], is_cebreak_o);
      check_flag("is_wfi_o", exp[1], is_wfi_o);
      check_flag("is_dret_o", exp[0], is_dret_o);
    end
  end
  @(posedge cov_assert_if);
  drive_idle();
endtask

task automatic test_ebreak_pc();
  logic [XLEN-1:0] pc;
  test_name = "ebreak_pc";
  for (int i = 0; i < 6; i++) begin
    pc = $random(seed);
    pc[0] = 1'b0;
    @(posedge cov_assert_if);
    wb_valid_i <= 1'b1;
    wb_pc_i    <= pc;
    wb_instr_i <= i[0] ? C_EBREAK_WORD : EBREAK_WORD;
    // Two ordinary retirements must leave the captured pc alone
    for (int n = 0; n < 2; n++) begin
      @(posedge cov_assert_if);
      wb_pc_i    <= pc + 32'd4;
      wb_instr_i <= NOP_WORD;
      @(negedge cov_assert_if);
      check_word("ebreak_pc_o", pc, ebreak_pc_o);
    end
  end
  @(posedge cov_assert_if);
  drive_idle();
endtask

task automatic test_cause();
  logic [31:0]     rnd;
  logic [XLEN-1:0] dcsr;
  logic            trig;
  logic            ebr;
  logic            func;
  logic            dm;
  logic [2:0]      exp_q;
  logic [2:0]      exp_next;
  test_name = "cause";
  exp_q = CAUSE_NONE;
  for (int i = 0; i < 24; i++) begin
    rnd  = $random(seed);
    // Trigger and debug mode kept rarer so lower priorities show up
    trig = rnd[0] & rnd[1];
    ebr  = rnd[3];
    func = rnd[6] | rnd[7];
    dm   = rnd[8] & rnd[9];
    dcsr = '0;
    dcsr[DCSR_EBREAKM_BIT] = rnd[2];
    dcsr[DCSR_STEP_BIT]    = rnd[5];
    @(posedge cov_assert_if);
    ctrl_state_i    <= func ? ST_FUNCTIONAL : ST_BOOT_SET;
    debug_mode_i    <= dm;
    trigger_match_i <= trig;
    debug_req_i     <= rnd[4];
    dcsr_i          <= dcsr;
    wb_valid_i      <= 1'b1;
    wb_instr_i      <= ebr ? (rnd[10] ? C_EBREAK_WORD : EBREAK_WORD) : NOP_WORD;
    if (!func || dm) exp_next = exp_q;
    else if (trig) exp_next = CAUSE_TRIGGER;
    else if (rnd[2] && ebr) exp_next = CAUSE_EBREAK;
    else if (rnd[4]) exp_next = CAUSE_HALTREQ;
    else if (rnd[5]) exp_next = CAUSE_STEP;
    else exp_next = CAUSE_NONE;
    @(negedge cov_assert_if);
    check_cause("cause_o", exp_q, cause_o);
    exp_q = exp_next;
  end
  @(posedge cov_assert_if);
  drive_idle();
  @(negedge cov_assert_if);
  check_cause("cause_o", exp_q, cause_o);
endtask

// One stimulus cycle, one quiet cycle, then the sleep state is checked
task automatic wfi_step(input logic wfi, input logic req, input logic dm, input logic step,
                        input logic [IRQ_W-1:0] irq, input logic [IRQ_W-1:0] mie,
                        input logic exp);
  logic [XLEN-1:0] dcsr;
  dcsr = '0;
  dcsr[DCSR_STEP_BIT] = step;
  @(posedge cov_assert_if);
  wb_valid_i   <= wfi;
  wb_instr_i   <= wfi ? WFI_WORD : NOP_WORD;
  debug_req_i  <= req;
  debug_mode_i <= dm;
  dcsr_i       <= dcsr;
  irq_i        <= irq;
  mie_i        <= mie;
  @(posedge cov_assert_if);
  drive_idle();
  @(negedge cov_assert_if);
  check_flag("in_wfi_o", exp, in_wfi_o);
endtask

task automatic test_wfi();
  logic [31:0]      rnd;
  logic [IRQ_W-1:0] line;
  test_name = "wfi";
  rnd  = $random(seed);
  line = '0;
  line[rnd[4:0]] = 1'b1;
  wfi_step(1'b1, 1'b1, 1'b0, 1'b0, '0, '0, 1'b0);
  wfi_step(1'b1, 1'b0, 1'b1, 1'b0, '0, '0, 1'b0);
  wfi_step(1'b1, 1'b0, 1'b0, 1'b1, '0, '0, 1'b0);
  wfi_step(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, 1'b1);
  // Pending line with its enable off
  wfi_step(1'b0, 1'b0, 1'b0, 1'b0, line, ~line, 1'b1);
  wfi_step(1'b0, 1'b0, 1'b0, 1'b0, line, line, 1'b0);
  wfi_step(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, 1'b1);
  wfi_step(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, 1'b0);
  wfi_step(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, 1'b1);
  // Wake and wfi together, wake wins
  wfi_step(1'b1, 1'b0, 1'b0, 1'b0, line, line, 1'b0);
endtask

task automatic fdi_step(input logic dm, input logic id, input logic wb, input logic exp);
  @(posedge cov_assert_if);
  debug_mode_i <= dm;
  id_valid_i   <= id;
  wb_valid_i   <= wb;
  wb_instr_i   <= NOP_WORD;
  @(negedge cov_assert_if);
  check_flag("first_debug_ins_o", exp, first_debug_ins_o);
endtask

// Two debug sessions, each with one pulse on its first retirement
task automatic test_first_debug();
  test_name = "first_debug";
  for (int s = 0; s < 2; s++) begin
    fdi_step(1'b1, 1'b0, 1'b0, 1'b0);
    fdi_step(1'b1, 1'b1, 1'b0, 1'b0);
    fdi_step(1'b1, 1'b0, 1'b1, 1'b1);
    fdi_step(1'b1, 1'b0, 1'b1, 1'b0);
    fdi_step(1'b1, 1'b1, 1'b1, 1'b0);
    fdi_step(1'b0, 1'b0, 1'b1, 1'b0);
    fdi_step(1'b0, 1'b0, 1'b0, 1'b0);
  end
  @(posedge cov_assert_if);
  drive_idle();
endtask

// Checks the result of the previous cycle, then updates the reference for this one
task automatic addr_step(input logic [2:0] state, input logic dm, input logic wb,
                         input logic ebr, input logic ill, input logic ecall,
                         input logic pcset, input logic [XLEN-1:0] haddr,
                         input logic [XLEN-1:0] eaddr);
  @(posedge cov_assert_if);
  ctrl_state_i        <= state;
  debug_mode_i        <= dm;
  wb_valid_i          <= wb;
  wb_instr_i          <= ebr ? EBREAK_WORD : NOP_WORD;
  illegal_insn_i      <= ill;
  ecall_insn_i        <= ecall;
  pc_set_i            <= pcset;
  dm_halt_addr_i      <= haddr;
  dm_exception_addr_i <= eaddr;
  @(negedge cov_assert_if);
  check_word("halt_addr_o", halt_exp, halt_addr_o);
  check_word("exc_addr_o", exc_exp, exc_addr_o);
  if (!halt_flag_m && state == ST_DEBUG_TAKEN) begin
    halt_exp    = {haddr[XLEN-1:2], 2'b00};
    halt_flag_m = 1'b1;
  end
  if (!dm || (ebr && wb)) halt_flag_m = 1'b0;
  if ((ill || ecall) && pcset && dm && wb) exc_exp = {eaddr[XLEN-1:2], 2'b00};
endtask

task automatic test_entry_addr();
  logic [XLEN-1:0] ha [3];
  logic [XLEN-1:0] ea [2];
  test_name = "entry_addr";
  for (int i = 0; i < 3; i++) ha[i] = $random(seed);
  for (int i = 0; i < 2; i++) ea[i] = $random(seed);
  addr_step(ST_FUNCTIONAL, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ha[0], ea[0]);
  addr_step(ST_DEBUG_TAKEN, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ha[0], ea[0]);
  addr_step(ST_DEBUG_TAKEN, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ha[1], ea[0]);
  // Ebreak in debug mode rearms the halt capture
  addr_step(ST_FUNCTIONAL, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, ha[1], ea[0]);
  addr_step(ST_DEBUG_TAKEN, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ha[1], ea[0]);
  addr_step(ST_FUNCTIONAL, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ha[2], ea[0]);
  addr_step(ST_DEBUG_TAKEN, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ha[2], ea[0]);
  // Exception capture needs every term of the condition
  addr_step(ST_FUNCTIONAL, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, ha[2], ea[0]);
  addr_step(ST_FUNCTIONAL, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, ha[2], ea[0]);
  addr_step(ST_FUNCTIONAL, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, ha[2], ea[1]);
  addr_step(ST_FUNCTIONAL, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, ha[2], ea[1]);
  addr_step(ST_FUNCTIONAL, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, ha[2], ea[1]);
  // Outside debug mode the halt capture rearms at once
  addr_step(ST_DEBUG_TAKEN, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ha[0], ea[1]);
  addr_step(ST_DEBUG_TAKEN, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ha[1], ea[1]);
  addr_step(ST_RESET, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
  @(posedge cov_assert_if);
  drive_idle();
endtask

`endif

/* verification/tb_debug_monitor.sv */
// Directed testbench for debug_monitor_top; inputs change on rising edges, checks sample on falling
`timescale 1ns/10ps
`default_nettype none

module tb_debug_monitor
  import dbg_mon_pkg::*;
();

  localparam int IRQ_W = 32;
  // Rough sum of all test lengths in clock cycles
  localparam int TEST_CYCLES     = 160;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  localparam logic [XLEN-1:0] NOP_WORD    = 32'h0000_0013;
  localparam logic [XLEN-1:0] EBREAK_WORD = {F12_EBREAK, 13'd0, OPC_SYSTEM};
  localparam logic [XLEN-1:0] WFI_WORD    = {F12_WFI, 13'd0, OPC_SYSTEM};
  localparam logic [XLEN-1:0] DRET_WORD   = {F12_DRET, 13'd0, OPC_SYSTEM};

  wire              cov_assert_if;
  logic             rst_n_i;
  logic             wb_valid_i;
  logic [XLEN-1:0]  wb_pc_i;
  logic [XLEN-1:0]  wb_instr_i;
  logic             id_valid_i;
  logic             debug_mode_i;
  logic             debug_req_i;
  logic             trigger_match_i;
  logic [XLEN-1:0]  dcsr_i;
  logic [2:0]       ctrl_state_i;
  logic [IRQ_W-1:0] irq_i;
  logic [IRQ_W-1:0] mie_i;
  logic             illegal_insn_i;
  logic             ecall_insn_i;
  logic             pc_set_i;
  logic [XLEN-1:0]  dm_halt_addr_i;
  logic [XLEN-1:0]  dm_exception_addr_i;
  logic             is_ebreak_o;
  logic             is_cebreak_o;
  logic             is_wfi_o;
  logic             is_dret_o;
  logic [XLEN-1:0]  ebreak_pc_o;
  logic [2:0]       cause_o;
  logic             in_wfi_o;
  logic             first_debug_ins_o;
  logic [XLEN-1:0]  halt_addr_o;
  logic [XLEN-1:0]  exc_addr_o;

  string           test_name;
  integer          seed;
  // Reference state for the entry address captures
  logic [XLEN-1:0] halt_exp;
  logic [XLEN-1:0] exc_exp;
  logic            halt_flag_m;

  tb_clk_gen #(
    .PERIOD_NS (100)
  ) tb_clk_gen_inst (
    .clk_o (cov_assert_if)
  );

  debug_monitor_top #(
    .IRQ_W (IRQ_W)
  ) debug_monitor_top_inst (
    .cov_assert_if       (cov_assert_if),
    .rst_n_i             (rst_n_i),
    .wb_valid_i          (wb_valid_i),
    .wb_pc_i             (wb_pc_i),
    .wb_instr_i          (wb_instr_i),
    .id_valid_i          (id_valid_i),
    .debug_mode_i        (debug_mode_i),
    .debug_req_i         (debug_req_i),
    .trigger_match_i     (trigger_match_i),
    .dcsr_i              (dcsr_i),
    .ctrl_state_i        (ctrl_state_i),
    .irq_i               (irq_i),
    .mie_i               (mie_i),
    .illegal_insn_i      (illegal_insn_i),
    .ecall_insn_i        (ecall_insn_i),
    .pc_set_i            (pc_set_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .is_ebreak_o         (is_ebreak_o),
    .is_cebreak_o        (is_cebreak_o),
    .is_wfi_o            (is_wfi_o),
    .is_dret_o           (is_dret_o),
    .ebreak_pc_o         (ebreak_pc_o),
    .cause_o             (cause_o),
    .in_wfi_o            (in_wfi_o),
    .first_debug_ins_o   (first_debug_ins_o),
    .halt_addr_o         (halt_addr_o),
    .exc_addr_o          (exc_addr_o)
  );

  // --------------------
  // Compare tasks
  // --------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %0b, actual %0b",
                          test_name, what, expected, actual));
    end
  endtask

  task automatic check_word(input string what, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                          test_name, what, expected, actual));
    end
  endtask

  task automatic check_cause(input string what, input logic [2:0] expected,
                             input logic [2:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                          test_name, what, expected, actual));
    end
  endtask

  // Flags as {ebreak, cebreak, wfi, dret}, taken from the instruction bit positions
  function automatic logic [3:0] decode_model(input logic valid, input logic [XLEN-1:0] w);
    logic base;
    base = (w[6:0] == OPC_SYSTEM) && (w[19:7] == 13'd0);
    if (!valid) return 4'b0000;
    return {base && (w[31:20] == F12_EBREAK), w == C_EBREAK_WORD,
            base && (w[31:20] == F12_WFI), base && (w[31:20] == F12_DRET)};
  endfunction

  task automatic drive_idle();
    wb_valid_i          <= 1'b0;
    wb_pc_i             <= '0;
    wb_instr_i          <= NOP_WORD;
    id_valid_i          <= 1'b0;
    debug_mode_i        <= 1'b0;
    debug_req_i         <= 1'b0;
    trigger_match_i     <= 1'b0;
    dcsr_i              <= '0;
    ctrl_state_i        <= ST_RESET;
    irq_i               <= '0;
    mie_i               <= '0;
    illegal_insn_i      <= 1'b0;
    ecall_insn_i        <= 1'b0;
    pc_set_i            <= 1'b0;
    dm_halt_addr_i      <= '0;
    dm_exception_addr_i <= '0;
  endtask

  `include "tb_tests.svh"

  // --------------------
  // Watchdog and sequence
  // --------------------

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge cov_assert_if);
    abort_run($sformatf("Timeout: tests did not finish within %0d clock cycles",
                        WATCHDOG_CYCLES));
  end

  initial begin
    seed        = 32'h73cfdf97;
    halt_exp    = '0;
    exc_exp     = '0;
    halt_flag_m = 1'b0;
    rst_n_i <= 1'b0;
    drive_idle();
    repeat (8) @(posedge cov_assert_if);
    rst_n_i <= 1'b1;
    test_reset_values();
    test_decode();
    test_ebreak_pc();
    test_cause();
    test_wfi();
    test_first_debug();
    test_entry_addr();
    $display("Simulation PASSED");
    $finish;
  end

endmodule : tb_debug_monitor

`default_nettype wire

/* tb.f */
+incdir+verification
hw/dbg_mon_pkg.sv
hw/wb_retire_if.sv
hw/retire_decoder.sv
hw/debug_cause_tracker.sv
hw/entry_addr_capture.sv
hw/debug_monitor_top.sv
verification/tb_clk_gen.sv
verification/tb_debug_monitor.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debug monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_debug_monitor \
  -f tb.f \
  -o tb_debug_monitor_sim

# Result comes from the log below
./obj_dir/tb_debug_monitor_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  echo "Testbench reported a failure, see $LOG"
  exit 1
fi
